// File: Makefile
TOP := tb_write_guard

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
	verilator --binary --assert -Wno-fatal -f verilog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only -Wall --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: verification/tb_write_guard.sv
`timescale 1ns/1ns
`default_nettype none

module tb_write_guard;
  import write_guard_pkg::*;

  // About 200 cycles of tests plus margin
  localparam int max_cycles = 400;

  logic         clk_i;
  logic         rst_ni;
  logic         aw_valid;
  logic         aw_ready;
  id_t          aw_id;
  addr_t        aw_addr;
  len_t         aw_len;
  logic         w_valid;
  logic         w_ready;
  logic         w_last;
  logic         b_valid;
  logic         b_ready;
  id_t          b_id;
  cnt_t         budget_aw;
  cnt_t         budget_beat;
  cnt_t         budget_b;
  logic         clear;
  logic         reset_req;
  logic         irq;
  fault_cause_e fault_cause;
  addr_t        fault_addr;
  int           seed;
  int           cycle_cnt = 0;

  write_guard u_write_guard (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_valid_i    (aw_valid),
    .aw_ready_i    (aw_ready),
    .aw_id_i       (aw_id),
    .aw_addr_i     (aw_addr),
    .aw_len_i      (aw_len),
    .w_valid_i     (w_valid),
    .w_ready_i     (w_ready),
    .w_last_i      (w_last),
    .b_valid_i     (b_valid),
    .b_ready_i     (b_ready),
    .b_id_i        (b_id),
    .budget_aw_i   (budget_aw),
    .budget_beat_i (budget_beat),
    .budget_b_i    (budget_b),
    .clear_i       (clear),
    .reset_req_o   (reset_req),
    .irq_o         (irq),
    .fault_cause_o (fault_cause),
    .fault_addr_o  (fault_addr)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      abort_run($sformatf("Timeout: run did not end within %0d cycles", max_cycles));
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_cause(input string name, input fault_cause_e got, input fault_cause_e exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic addr_t rand_addr();
    return addr_t'($random(seed));
  endfunction

  task automatic send_aw(input id_t id, input addr_t addr, input len_t len);
    aw_valid = 1'b1;
    aw_ready = 1'b1;
    aw_id    = id;
    aw_addr  = addr;
    aw_len   = len;
    @(negedge clk_i);
    aw_valid = 1'b0;
    aw_ready = 1'b0;
  endtask

  // AW held valid while the subordinate refuses it
  task automatic stall_aw(input id_t id, input addr_t addr);
    aw_valid = 1'b1;
    aw_ready = 1'b0;
    aw_id    = id;
    aw_addr  = addr;
    aw_len   = '0;
  endtask

  task automatic release_aw();
    aw_ready = 1'b1;
    @(negedge clk_i);
    aw_valid = 1'b0;
    aw_ready = 1'b0;
  endtask

  task automatic send_w_burst(input int beats);
    for (int i = 0; i < beats; i++) begin
      w_valid = 1'b1;
      w_ready = 1'b1;
      w_last  = (i == beats - 1);
      @(negedge clk_i);
    end
    w_valid = 1'b0;
    w_ready = 1'b0;
    w_last  = 1'b0;
  endtask

  task automatic send_b(input id_t id);
    b_valid = 1'b1;
    b_ready = 1'b1;
    b_id    = id;
    @(negedge clk_i);
    b_valid = 1'b0;
    b_ready = 1'b0;
  endtask

  task automatic wait_reset_req(input int limit, input string what);
    int n;
    n = 0;
    while (reset_req !== 1'b1) begin
      if (n >= limit) begin
        abort_run($sformatf("No reset request within %0d cycles after %s", limit, what));
      end else begin
        @(negedge clk_i);
        n++;
      end
    end
  endtask

  task automatic expect_fault(input fault_cause_e cause, input addr_t addr, input int limit,
                              input string what);
    wait_reset_req(limit, what);
    check_bit("irq_o", irq, 1'b1);
    check_cause("fault_cause_o", fault_cause, cause);
    check_addr("fault_addr_o", fault_addr, addr);
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_bit("reset_req_o", reset_req, 1'b0);
    end
  endtask

  task automatic pulse_clear();
    clear = 1'b1;
    @(negedge clk_i);
    clear = 1'b0;
    check_bit("reset_req_o", reset_req, 1'b0);
    check_cause("fault_cause_o", fault_cause, FAULT_NONE);
  endtask

  task automatic clean_burst();
    send_aw(4'd1, rand_addr(), 8'd3);
    send_w_burst(4);
    @(negedge clk_i);
    send_b(4'd1);
    expect_quiet(int'(budget_b) + 5);
    pulse_clear();
  endtask

  task automatic aw_wait_timeout();
    addr_t addr;
    addr = rand_addr();
    stall_aw(4'd2, addr);
    expect_fault(FAULT_AW_WAIT, addr, int'(budget_aw) + 3, "AW stall");
    release_aw();
    pulse_clear();
  endtask

  task automatic w_burst_timeout();
    addr_t addr;
    addr = rand_addr();
    send_aw(4'd3, addr, 8'd1);
    // First of two beats, then the burst stalls
    w_valid = 1'b1;
    w_ready = 1'b1;
    @(negedge clk_i);
    w_valid = 1'b0;
    w_ready = 1'b0;
    expect_fault(FAULT_W_BURST, addr, int'(budget_beat) * 2 + 3, "first W beat");
    pulse_clear();
  endtask

  task automatic b_response_faults();
    addr_t addr;
    addr = rand_addr();
    send_aw(4'd4, addr, 8'd0);
    send_w_burst(1);
    expect_fault(FAULT_B_WAIT, addr, int'(budget_b) + 3, "last W beat");
    pulse_clear();
    send_b(4'd9);
    expect_fault(FAULT_UNWANTED_B, '0, 3, "unexpected B");
    pulse_clear();
  endtask

  task automatic reorder_and_overflow();
    addr_t addr;
    send_aw(4'd2, rand_addr(), 8'd0);
    send_aw(4'd3, rand_addr(), 8'd0);
    send_w_burst(1);
    send_w_burst(1);
    @(negedge clk_i);
    // Responses come back in reverse order
    send_b(4'd3);
    send_b(4'd2);
    expect_quiet(int'(budget_b) + 5);
    for (int i = 0; i < 5; i++) begin
      addr = rand_addr();
      send_aw(id_t'(5 + i), addr, 8'd0);
    end
    expect_fault(FAULT_OVERFLOW, addr, 3, "fifth AW");
    pulse_clear();
    // Drain the four queued writes
    send_w_burst(1);
    send_w_burst(1);
    send_w_burst(1);
    send_w_burst(1);
    @(negedge clk_i);
    for (int i = 0; i < 4; i++) begin
      send_b(id_t'(5 + i));
    end
    expect_quiet(int'(budget_b) + 5);
    pulse_clear();
  endtask

  task automatic first_fault_kept();
    addr_t addr;
    send_b(4'd10);
    expect_fault(FAULT_UNWANTED_B, '0, 3, "unexpected B");
    stall_aw(4'd6, rand_addr());
    repeat (int'(budget_aw) + 3) @(negedge clk_i);
    check_bit("reset_req_o", reset_req, 1'b1);
    check_cause("fault_cause_o", fault_cause, FAULT_UNWANTED_B);
    check_addr("fault_addr_o", fault_addr, '0);
    release_aw();
    pulse_clear();
    addr = rand_addr();
    stall_aw(4'd7, addr);
    expect_fault(FAULT_AW_WAIT, addr, int'(budget_aw) + 3, "AW stall after clear");
    release_aw();
    pulse_clear();
  endtask

  initial begin
    seed        = 91115;
    rst_ni      = 1'b0;
    aw_valid    = 1'b0;
    aw_ready    = 1'b0;
    aw_id       = '0;
    aw_addr     = '0;
    aw_len      = '0;
    w_valid     = 1'b0;
    w_ready     = 1'b0;
    w_last      = 1'b0;
    b_valid     = 1'b0;
    b_ready     = 1'b0;
    b_id        = '0;
    budget_aw   = 12'd8;
    budget_beat = 12'd4;
    budget_b    = 12'd20;
    clear       = 1'b0;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    check_bit("reset_req_o", reset_req, 1'b0);
    check_bit("irq_o", irq, 1'b0);
    check_cause("fault_cause_o", fault_cause, FAULT_NONE);
    clean_burst();
    aw_wait_timeout();
    w_burst_timeout();
    b_response_faults();
    reorder_and_overflow();
    first_fault_kept();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/write_guard_props.sv
`timescale 1ns/1ns
`default_nettype none

module write_guard_props (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          clear_i,
  input logic                          reset_req_i,
  input logic                          irq_i,
  input write_guard_pkg::fault_cause_e fault_cause_i
);
  import write_guard_pkg::*;

  // Interrupt is a single-cycle pulse
  irq_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni) irq_i |=> !irq_i)
    else $error("irq_o high on two consecutive cycles");

  // Reset request is sticky until software clears it
  req_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (reset_req_i && !clear_i) |=> reset_req_i)
    else $error("reset_req_o fell without clear_i");

  cause_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reset_req_i |-> (fault_cause_i != FAULT_NONE))
    else $error("fault_cause_o is FAULT_NONE while reset_req_o is high");

endmodule

bind write_guard write_guard_props u_write_guard_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .clear_i       (clear_i),
  .reset_req_i   (reset_req_o),
  .irq_i         (irq_o),
  .fault_cause_i (fault_cause_o)
);

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/write_guard_pkg.sv
verilog/aw_tracker.sv
verilog/w_burst_timer.sv
verilog/b_response_checker.sv
verilog/fault_reporter.sv
verilog/write_guard.sv
verification/write_guard_props.sv
verification/tb_write_guard.sv

// File: verilog/aw_tracker.sv
`timescale 1ns/1ns
`default_nettype none

`include "write_guard_config.svh"

module aw_tracker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      aw_valid_i,
  input  logic                      aw_ready_i,
  input  write_guard_pkg::id_t      aw_id_i,
  input  write_guard_pkg::addr_t    aw_addr_i,
  input  write_guard_pkg::len_t     aw_len_i,
  input  write_guard_pkg::cnt_t     budget_aw_i,
  output logic                      rec_valid_o,
  input  logic                      rec_ready_i,
  output write_guard_pkg::txn_rec_t rec_o,
  output logic                      fault_o,
  output logic                      aw_overflow_o,
  output write_guard_pkg::addr_t    fault_addr_o
);
  import write_guard_pkg::*;

  localparam int unsigned queue_depth = `WG_QUEUE_DEPTH;
  localparam int unsigned ptr_w = $clog2(queue_depth);

  // Accepted AWs waiting for their W burst
  txn_rec_t         mem_q [queue_depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [ptr_w:0]   count_q;

  cnt_t  wait_cnt_q;
  logic  timed_out_q;
  logic  fault_q;
  logic  overflow_q;
  addr_t fault_addr_q;

  logic aw_hs;
  logic aw_stall;
  logic push;
  logic pop;
  logic full;
  logic wait_fault;
  logic overflow;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign aw_hs    = aw_valid_i && aw_ready_i;
  assign aw_stall = aw_valid_i && !aw_ready_i;
  assign pop      = rec_valid_o && rec_ready_i;
  assign full     = (count_q == (ptr_w + 1)'(queue_depth));

  // Fires once, on the stall cycle that takes the count past the budget
  assign wait_fault = aw_stall && !timed_out_q && (wait_cnt_q >= budget_aw_i);

  // A timed-out AW is dropped when it finally completes
  assign overflow = aw_hs && !timed_out_q && full && !pop;
  assign push     = aw_hs && !timed_out_q && !overflow;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_cnt_q  <= '0;
      timed_out_q <= 1'b0;
      fault_q     <= 1'b0;
      overflow_q  <= 1'b0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
    end else begin
      fault_q    <= wait_fault;
      overflow_q <= overflow;
      if (!aw_valid_i || aw_hs) begin
        wait_cnt_q  <= '0;
        timed_out_q <= 1'b0;
      end else if (!timed_out_q) begin
        wait_cnt_q  <= wait_cnt_q + 1'b1;
        timed_out_q <= wait_fault;
      end
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= '{id: aw_id_i, addr: aw_addr_i, len: aw_len_i};
    end
    if (wait_fault || overflow) begin
      fault_addr_q <= aw_addr_i;
    end
  end

  assign rec_valid_o   = (count_q != '0);
  assign rec_o         = mem_q[rd_ptr_q];
  assign fault_o       = fault_q;
  assign aw_overflow_o = overflow_q;
  assign fault_addr_o  = fault_addr_q;

endmodule

`default_nettype wire

// File: verilog/b_response_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "write_guard_config.svh"

module b_response_checker (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         b_valid_i,
  input  logic                         b_ready_i,
  input  write_guard_pkg::id_t         b_id_i,
  input  write_guard_pkg::cnt_t        budget_b_i,
  input  logic                         rec_valid_i,
  output logic                         rec_ready_o,
  input  write_guard_pkg::txn_rec_t    rec_i,
  output logic                         fault_o,
  output write_guard_pkg::fault_cause_e fault_cause_o,
  output write_guard_pkg::addr_t       fault_addr_o
);
  import write_guard_pkg::*;

  localparam int unsigned depth = `WG_QUEUE_DEPTH;
  localparam int unsigned idx_w = $clog2(depth);

  wr_phase_e    phase_q [depth];
  cnt_t         age_q [depth];
  txn_rec_t     rec_q [depth];
  logic         fault_q;
  fault_cause_e cause_q;
  addr_t        fault_addr_q;

  logic             b_hs;
  logic             hit;
  logic [idx_w-1:0] hit_idx;
  cnt_t             hit_age;
  logic             free_found;
  logic [idx_w-1:0] free_idx;
  logic [depth-1:0] tmo;
  addr_t            tmo_addr;
  logic             absorb;
  logic             alloc;
  logic             unwanted;

  assign b_hs = b_valid_i && b_ready_i;

  always_comb begin
    hit        = 1'b0;
    hit_idx    = '0;
    hit_age    = '0;
    free_found = 1'b0;
    free_idx   = '0;
    tmo_addr   = '0;
    // Oldest pending entry with the response ID
    for (int i = 0; i < depth; i++) begin
      if ((phase_q[i] == PHASE_RESP) && (rec_q[i].id == b_id_i) &&
          (!hit || age_q[i] > hit_age)) begin
        hit     = 1'b1;
        hit_idx = idx_w'(i);
        hit_age = age_q[i];
      end
    end
    for (int i = depth - 1; i >= 0; i--) begin
      tmo[i] = (phase_q[i] == PHASE_RESP) && (age_q[i] >= budget_b_i) &&
               !(b_hs && hit && (hit_idx == idx_w'(i)));
      if (phase_q[i] == PHASE_IDLE) begin
        free_found = 1'b1;
        free_idx   = idx_w'(i);
      end
      if (tmo[i]) begin
        tmo_addr = rec_q[i].addr;
      end
    end
  end

  // B may complete in the cycle its record arrives
  assign absorb      = b_hs && !hit && rec_valid_i && (rec_i.id == b_id_i);
  assign rec_ready_o = free_found || absorb;
  assign alloc       = rec_valid_i && free_found && !absorb;
  assign unwanted    = b_hs && !hit && !absorb;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < depth; i++) begin
        phase_q[i] <= PHASE_IDLE;
        age_q[i]   <= '0;
      end
      fault_q <= 1'b0;
    end else begin
      fault_q <= (|tmo) || unwanted;
      for (int i = 0; i < depth; i++) begin
        if (alloc && (free_idx == idx_w'(i))) begin
          phase_q[i] <= PHASE_RESP;
          age_q[i]   <= '0;
        end else if ((b_hs && hit && (hit_idx == idx_w'(i))) || tmo[i]) begin
          phase_q[i] <= PHASE_IDLE;
        end else if (phase_q[i] == PHASE_RESP) begin
          age_q[i] <= age_q[i] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc) begin
      rec_q[free_idx] <= rec_i;
    end
    // A wait fault outranks an unwanted response
    if (|tmo) begin
      cause_q      <= FAULT_B_WAIT;
      fault_addr_q <= tmo_addr;
    end else if (unwanted) begin
      cause_q      <= FAULT_UNWANTED_B;
      fault_addr_q <= '0;
    end
  end

  assign fault_o       = fault_q;
  assign fault_cause_o = cause_q;
  assign fault_addr_o  = fault_addr_q;

endmodule

`default_nettype wire

// File: verilog/fault_reporter.sv
`timescale 1ns/1ns
`default_nettype none

module fault_reporter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          aw_fault_i,
  input  logic                          aw_overflow_i,
  input  write_guard_pkg::addr_t        aw_fault_addr_i,
  input  logic                          w_fault_i,
  input  write_guard_pkg::addr_t        w_fault_addr_i,
  input  logic                          b_fault_i,
  input  write_guard_pkg::fault_cause_e b_fault_cause_i,
  input  write_guard_pkg::addr_t        b_fault_addr_i,
  output logic                          reset_req_o,
  output logic                          irq_o,
  output write_guard_pkg::fault_cause_e fault_cause_o,
  output write_guard_pkg::addr_t        fault_addr_o
);
  import write_guard_pkg::*;

  fault_cause_e sel_cause;
  addr_t        sel_addr;
  logic         latch;

  logic         reset_req_q;
  logic         irq_q;
  fault_cause_e cause_q;
  addr_t        addr_q;

  // Fixed priority in enum order
  always_comb begin
    sel_cause = FAULT_NONE;
    sel_addr  = '0;
    if (aw_fault_i) begin
      sel_cause = FAULT_AW_WAIT;
      sel_addr  = aw_fault_addr_i;
    end else if (w_fault_i) begin
      sel_cause = FAULT_W_BURST;
      sel_addr  = w_fault_addr_i;
    end else if (b_fault_i) begin
      sel_cause = b_fault_cause_i;
      sel_addr  = b_fault_addr_i;
    end else if (aw_overflow_i) begin
      sel_cause = FAULT_OVERFLOW;
      sel_addr  = aw_fault_addr_i;
    end
  end

  // Only the first fault is kept until software clears it
  assign latch = (sel_cause != FAULT_NONE) && !reset_req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_req_q <= 1'b0;
      irq_q       <= 1'b0;
      cause_q     <= FAULT_NONE;
      addr_q      <= '0;
    end else begin
      irq_q <= latch;
      if (latch) begin
        reset_req_q <= 1'b1;
        cause_q     <= sel_cause;
        addr_q      <= sel_addr;
      end else if (clear_i) begin
        reset_req_q <= 1'b0;
        cause_q     <= FAULT_NONE;
      end
    end
  end

  assign reset_req_o   = reset_req_q;
  assign irq_o         = irq_q;
  assign fault_cause_o = cause_q;
  assign fault_addr_o  = addr_q;

endmodule

`default_nettype wire

// File: verilog/w_burst_timer.sv
`timescale 1ns/1ns
`default_nettype none

module w_burst_timer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      w_valid_i,
  input  logic                      w_ready_i,
  input  logic                      w_last_i,
  input  write_guard_pkg::cnt_t     budget_beat_i,
  input  logic                      rec_valid_i,
  output logic                      rec_ready_o,
  input  write_guard_pkg::txn_rec_t rec_i,
  output logic                      rec_valid_o,
  input  logic                      rec_ready_i,
  output write_guard_pkg::txn_rec_t rec_o,
  output logic                      fault_o,
  output write_guard_pkg::addr_t    fault_addr_o
);
  import write_guard_pkg::*;

  // Wide enough for budget times 256 beats
  localparam int unsigned allow_w = $bits(cnt_t) + $bits(len_t) + 1;

  wr_phase_e          state_q;
  wr_phase_e          state_d;
  txn_rec_t           rec_q;
  logic [allow_w-1:0] allow_q;
  logic [allow_w-1:0] beat_cnt_q;
  logic               fault_q;
  addr_t              fault_addr_q;

  logic w_beat;
  logic slot_free;
  logic take;
  logic timeout;

  assign w_beat = w_valid_i && w_ready_i;

  // The held record may leave in the same cycle that the next burst starts
  assign slot_free   = (state_q == PHASE_IDLE) || ((state_q == PHASE_RESP) && rec_ready_i);
  assign rec_ready_o = slot_free && w_beat;
  assign take        = rec_ready_o && rec_valid_i;

  assign timeout = (state_q == PHASE_DATA) && !(w_beat && w_last_i) && (beat_cnt_q >= allow_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      PHASE_DATA: begin
        if (timeout) begin
          state_d = PHASE_IDLE;
        end else if (w_beat && w_last_i) begin
          state_d = PHASE_RESP;
        end
      end
      PHASE_RESP: begin
        if (rec_ready_i) begin
          state_d = PHASE_IDLE;
        end
      end
      default: state_d = PHASE_IDLE;
    endcase
    // Single-beat bursts go straight to the response phase
    if (take) begin
      state_d = w_last_i ? PHASE_RESP : PHASE_DATA;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= PHASE_IDLE;
      beat_cnt_q <= '0;
      fault_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      fault_q <= timeout;
      if (take) begin
        beat_cnt_q <= '0;
      end else if (state_q == PHASE_DATA) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      rec_q   <= rec_i;
      allow_q <= allow_w'(budget_beat_i) * (allow_w'(rec_i.len) + 1'b1);
    end
    if (timeout) begin
      fault_addr_q <= rec_q.addr;
    end
  end

  assign rec_valid_o  = (state_q == PHASE_RESP);
  assign rec_o        = rec_q;
  assign fault_o      = fault_q;
  assign fault_addr_o = fault_addr_q;

endmodule

`default_nettype wire

// File: verilog/write_guard.sv
`timescale 1ns/1ns
`default_nettype none

module write_guard (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          aw_valid_i,
  input  logic                          aw_ready_i,
  input  write_guard_pkg::id_t          aw_id_i,
  input  write_guard_pkg::addr_t        aw_addr_i,
  input  write_guard_pkg::len_t         aw_len_i,
  input  logic                          w_valid_i,
  input  logic                          w_ready_i,
  input  logic                          w_last_i,
  input  logic                          b_valid_i,
  input  logic                          b_ready_i,
  input  write_guard_pkg::id_t          b_id_i,
  input  write_guard_pkg::cnt_t         budget_aw_i,
  input  write_guard_pkg::cnt_t         budget_beat_i,
  input  write_guard_pkg::cnt_t         budget_b_i,
  input  logic                          clear_i,
  output logic                          reset_req_o,
  output logic                          irq_o,
  output write_guard_pkg::fault_cause_e fault_cause_o,
  output write_guard_pkg::addr_t        fault_addr_o
);
  import write_guard_pkg::*;

  // Address stage to data stage
  logic     aw_rec_valid;
  logic     aw_rec_ready;
  txn_rec_t aw_rec;
  logic     aw_fault;
  logic     aw_overflow;
  addr_t    aw_fault_addr;

  // Data stage to response stage
  logic     w_rec_valid;
  logic     w_rec_ready;
  txn_rec_t w_rec;
  logic     w_fault;
  addr_t    w_fault_addr;

  logic         b_fault;
  fault_cause_e b_fault_cause;
  addr_t        b_fault_addr;

  aw_tracker u_aw_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_i    (aw_ready_i),
    .aw_id_i       (aw_id_i),
    .aw_addr_i     (aw_addr_i),
    .aw_len_i      (aw_len_i),
    .budget_aw_i   (budget_aw_i),
    .rec_valid_o   (aw_rec_valid),
    .rec_ready_i   (aw_rec_ready),
    .rec_o         (aw_rec),
    .fault_o       (aw_fault),
    .aw_overflow_o (aw_overflow),
    .fault_addr_o  (aw_fault_addr)
  );

  w_burst_timer u_w_burst_timer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .w_valid_i     (w_valid_i),
    .w_ready_i     (w_ready_i),
    .w_last_i      (w_last_i),
    .budget_beat_i (budget_beat_i),
    .rec_valid_i   (aw_rec_valid),
    .rec_ready_o   (aw_rec_ready),
    .rec_i         (aw_rec),
    .rec_valid_o   (w_rec_valid),
    .rec_ready_i   (w_rec_ready),
    .rec_o         (w_rec),
    .fault_o       (w_fault),
    .fault_addr_o  (w_fault_addr)
  );

  b_response_checker u_b_response_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .b_valid_i     (b_valid_i),
    .b_ready_i     (b_ready_i),
    .b_id_i        (b_id_i),
    .budget_b_i    (budget_b_i),
    .rec_valid_i   (w_rec_valid),
    .rec_ready_o   (w_rec_ready),
    .rec_i         (w_rec),
    .fault_o       (b_fault),
    .fault_cause_o (b_fault_cause),
    .fault_addr_o  (b_fault_addr)
  );

  fault_reporter u_fault_reporter (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .clear_i         (clear_i),
    .aw_fault_i      (aw_fault),
    .aw_overflow_i   (aw_overflow),
    .aw_fault_addr_i (aw_fault_addr),
    .w_fault_i       (w_fault),
    .w_fault_addr_i  (w_fault_addr),
    .b_fault_i       (b_fault),
    .b_fault_cause_i (b_fault_cause),
    .b_fault_addr_i  (b_fault_addr),
    .reset_req_o     (reset_req_o),
    .irq_o           (irq_o),
    .fault_cause_o   (fault_cause_o),
    .fault_addr_o    (fault_addr_o)
  );

endmodule

`default_nettype wire

// File: verilog/write_guard_config.svh
`ifndef WRITE_GUARD_CONFIG_SVH
`define WRITE_GUARD_CONFIG_SVH

// AXI ID width
`define WG_ID_W 4

// Address width
`define WG_ADDR_W 32

// AW len field width
`define WG_LEN_W 8

// Width of budgets and cycle counters
`define WG_CNT_W 12

// Entries in each stage queue
`define WG_QUEUE_DEPTH 4

`endif

// File: verilog/write_guard_pkg.sv
`default_nettype none

`include "write_guard_config.svh"

package write_guard_pkg;

  typedef logic [`WG_ID_W-1:0]   id_t;
  typedef logic [`WG_ADDR_W-1:0] addr_t;
  typedef logic [`WG_LEN_W-1:0]  len_t;
  typedef logic [`WG_CNT_W-1:0]  cnt_t;

  // Write record passed from stage to stage
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } txn_rec_t;

  // Lower value wins when faults collide
  typedef enum logic [2:0] {
    FAULT_NONE,
    FAULT_AW_WAIT,
    FAULT_W_BURST,
    FAULT_B_WAIT,
    FAULT_UNWANTED_B,
    FAULT_OVERFLOW
  } fault_cause_e;

  typedef enum logic [1:0] {
    PHASE_IDLE,
    PHASE_ADDR,
    PHASE_DATA,
    PHASE_RESP
  } wr_phase_e;

endpackage

`default_nettype wire
